/* include/systolic_settings.svh */
`ifndef SYSTOLIC_SETTINGS_SVH
`define SYSTOLIC_SETTINGS_SVH

////////////////////
// Array geometry
////////////////////

// Grid dimension N, the array holds N by N cells
`define SYS_MATRIX_SIZE 4

// Number of diagonals that leave the grid
`define SYS_NUM_DIAG (2 * `SYS_MATRIX_SIZE - 1)

////////////////////
// Data path
////////////////////

// Width of every operand and partial sum
// Sums wrap modulo 2**SYS_DATA_WIDTH
`define SYS_DATA_WIDTH 16

// Parallel lanes carried by one left operand
`define SYS_LANES 6

`endif

/* logic/systolic_pkg.sv */
`include "systolic_settings.svh"

package systolic_pkg;

    ////////////////////
    // Scalar and lane types
    ////////////////////

    // One data word, also the shared top operand of a column
    typedef logic [`SYS_DATA_WIDTH-1:0] operand_t;

    // Lane vector
    // Used for left operands and for partial sums alike
    typedef operand_t [`SYS_LANES-1:0] lane_vec_t;

    ////////////////////
    // Edge buses
    ////////////////////

    // One lane vector per grid row
    typedef lane_vec_t [`SYS_MATRIX_SIZE-1:0] left_bus_t;

    // One scalar per grid column
    typedef operand_t [`SYS_MATRIX_SIZE-1:0] top_bus_t;

    // Skewed operand front as it enters the grid
    typedef struct packed {
        left_bus_t left;
        top_bus_t  top;
    } grid_edge_t;

    ////////////////////
    // Results
    ////////////////////

    // Element d is diagonal d
    // d = column - row + N - 1
    typedef lane_vec_t [`SYS_NUM_DIAG-1:0] diag_result_t;

endpackage

/* logic/operand_skew.sv */
`timescale 1ns/1ps

`include "systolic_settings.svh"

// Triangular delay bank in front of the grid
// Channel k is delayed by k cycles so that the operands
// of row/column k meet the wave front k cells later
module operand_skew #(
    parameter type payload_t = systolic_pkg::operand_t
) (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  payload_t [`SYS_MATRIX_SIZE-1:0]      din,
    output payload_t [`SYS_MATRIX_SIZE-1:0]      dout
);

    ////////////////////
    // Delay chains
    ////////////////////

    genvar k;

    generate
        for (k = 0; k < `SYS_MATRIX_SIZE; k = k + 1) begin : g_chan
            if (k == 0) begin : g_wire
                // First channel has no skew at all
                assign dout[k] = din[k];
            end else begin : g_chain
                // Stage 0 takes the input, stage k-1 drives the output
                payload_t [k-1:0] stage_q;

                always_ff @(posedge clk or negedge arst_n) begin
                    if (!arst_n) begin
                        // Everything before reset counts as zero data
                        stage_q <= '0;
                    end else begin
                        stage_q[0] <= din[k];
                        // Shift towards the output end
                        for (int s = 1; s < k; s++) begin
                            stage_q[s] <= stage_q[s-1];
                        end
                    end
                end

                // Last stage feeds the grid edge
                assign dout[k] = stage_q[k-1];
            end
        end
    endgenerate

endmodule

/* logic/mac_cell.sv */
`timescale 1ns/1ps

`include "systolic_settings.svh"

// Processing cell of the systolic array
// a travels right, b travels down, c travels diagonally
module mac_cell (
    input  logic                  clk,
    input  logic                  arst_n,
    input  systolic_pkg::lane_vec_t a_in,
    input  systolic_pkg::operand_t  b_in,
    input  systolic_pkg::lane_vec_t c_in,
    output systolic_pkg::lane_vec_t a_out,
    output systolic_pkg::operand_t  b_out,
    output systolic_pkg::lane_vec_t c_out
);

    import systolic_pkg::*;

    ////////////////////
    // Lane arithmetic
    ////////////////////

    // Next partial sum for every lane
    lane_vec_t sum_next;

    always_comb begin
        for (int l = 0; l < `SYS_LANES; l++) begin
            // Same top scalar multiplies every lane
            // Result truncates to the word width
            sum_next[l] = c_in[l] + a_in[l] * b_in;
        end
    end

    ////////////////////
    // Output registers
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_out <= '0;
            b_out <= '0;
            c_out <= '0;
        end else begin
            // Operands hop to the neighbours unchanged
            a_out <= a_in;
            b_out <= b_in;
            // Accumulated sum moves on down-right
            c_out <= sum_next;
        end
    end

endmodule

/* logic/mac_grid.sv */
`timescale 1ns/1ps

`include "systolic_settings.svh"

// N by N grid of MAC cells
// Operands enter at the left and top edges already skewed
// Sums run diagonally and leave at the right or bottom edge
module mac_grid (
    input  logic                       clk,
    input  logic                       arst_n,
    input  systolic_pkg::grid_edge_t   edge_in,
    output systolic_pkg::diag_result_t result
);

    import systolic_pkg::*;

    ////////////////////
    // Cell outputs
    ////////////////////

    // Registered outputs of cell (i,j), indexed [row][column]
    // a feeds (i,j+1), b feeds (i+1,j), c feeds (i+1,j+1)
    lane_vec_t a_q [`SYS_MATRIX_SIZE-1:0][`SYS_MATRIX_SIZE-1:0];
    operand_t  b_q [`SYS_MATRIX_SIZE-1:0][`SYS_MATRIX_SIZE-1:0];
    lane_vec_t c_q [`SYS_MATRIX_SIZE-1:0][`SYS_MATRIX_SIZE-1:0];

    genvar i;
    genvar j;

    ////////////////////
    // Cell array
    ////////////////////

    generate
        for (i = 0; i < `SYS_MATRIX_SIZE; i = i + 1) begin : g_row
            for (j = 0; j < `SYS_MATRIX_SIZE; j = j + 1) begin : g_col
                // Inputs selected for this cell
                lane_vec_t a_src;
                operand_t  b_src;
                lane_vec_t c_src;

                // Horizontal link
                if (j == 0) begin : g_a_edge
                    assign a_src = edge_in.left[i];
                end else begin : g_a_link
                    assign a_src = a_q[i][j-1];
                end

                // Vertical link
                if (i == 0) begin : g_b_edge
                    assign b_src = edge_in.top[j];
                end else begin : g_b_link
                    assign b_src = b_q[i-1][j];
                end

                // Diagonal link
                // A diagonal starts from zero at the first row or column
                if (i == 0 || j == 0) begin : g_c_zero
                    assign c_src = '0;
                end else begin : g_c_link
                    assign c_src = c_q[i-1][j-1];
                end

                mac_cell u_cell (
                    .clk    (clk),
                    .arst_n (arst_n),
                    .a_in   (a_src),
                    .b_in   (b_src),
                    .c_in   (c_src),
                    .a_out  (a_q[i][j]),
                    .b_out  (b_q[i][j]),
                    .c_out  (c_q[i][j])
                );
            end
        end
    endgenerate

    ////////////////////
    // Edge results
    ////////////////////

    generate
        // Bottom row exits
        // Cell (N-1,j) ends diagonal j, the corner ends diagonal N-1
        for (j = 0; j < `SYS_MATRIX_SIZE; j = j + 1) begin : g_bottom
            assign result[j] = c_q[`SYS_MATRIX_SIZE-1][j];
        end

        // Right column exits above the corner
        // Cell (i,N-1) ends diagonal 2N-2-i
        for (i = 0; i < `SYS_MATRIX_SIZE - 1; i = i + 1) begin : g_right
            assign result[2*`SYS_MATRIX_SIZE-2-i] = c_q[i][`SYS_MATRIX_SIZE-1];
        end
    endgenerate

endmodule

/* logic/systolic_top.sv */
`timescale 1ns/1ps

// Top level of the systolic MAC array
// Two skew banks line up the operand waves, the grid consumes them
module systolic_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  systolic_pkg::left_bus_t    left,
    input  systolic_pkg::top_bus_t     top,
    output systolic_pkg::diag_result_t result
);

    import systolic_pkg::*;

    ////////////////////
    // Skewed operands
    ////////////////////

    // Row i arrives i cycles late
    left_bus_t  left_skew;
    // Column j arrives j cycles late
    top_bus_t   top_skew;
    // Combined front entering the grid
    grid_edge_t edge_front;

    ////////////////////
    // Skew banks
    ////////////////////

    // Left bank carries full lane vectors
    operand_skew #(
        .payload_t (lane_vec_t)
    ) u_left_skew (
        .clk    (clk),
        .arst_n (arst_n),
        .din    (left),
        .dout   (left_skew)
    );

    // Top bank carries one scalar per column
    operand_skew #(
        .payload_t (operand_t)
    ) u_top_skew (
        .clk    (clk),
        .arst_n (arst_n),
        .din    (top),
        .dout   (top_skew)
    );

    ////////////////////
    // Grid
    ////////////////////

    // Both banks merge into a single edge bus
    assign edge_front.left = left_skew;
    assign edge_front.top  = top_skew;

    mac_grid u_grid (
        .clk     (clk),
        .arst_n  (arst_n),
        .edge_in (edge_front),
        .result  (result)
    );

endmodule

/* bench/systolic_tb.sv */
`timescale 1ns/1ps

`include "systolic_settings.svh"

module systolic_tb;

    import systolic_pkg::*;

    localparam int N           = `SYS_MATRIX_SIZE;
    localparam int LANES       = `SYS_LANES;
    localparam int NUM_DIAG    = `SYS_NUM_DIAG;
    localparam int CLK_PERIOD  = 20;
    localparam int NUM_ROWS    = 6;
    // Long enough for a constant front to cross skew and grid
    localparam int SETTLE_HOLD = 2 * N + 1;
    // Row that carries all-ones operands
    localparam int ONES_ROW    = 2;

    // One table entry
    // Operand values, cycles to hold them, random and settle flags
    typedef struct packed {
        left_bus_t left;
        top_bus_t  top;
        int        hold;
        bit        rand_en;
        bit        settle_chk;
    } stim_row_t;

    logic         clk;
    logic         arst_n;
    left_bus_t    left;
    top_bus_t     top;
    diag_result_t result;

    stim_row_t   stim_tbl [NUM_ROWS];
    // Operands as sampled at every rising edge, zero while in reset
    left_bus_t   hist_left [$];
    top_bus_t    hist_top [$];
    bit          table_ready;

    systolic_top dut0 (
        .clk    (clk),
        .arst_n (arst_n),
        .left   (left),
        .top    (top),
        .result (result)
    );

    ////////////////////
    // Clock and history
    ////////////////////

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Inputs only move 2 ns after the edge, so they are stable here
    always @(posedge clk) begin
        if (!arst_n) begin
            hist_left.push_back('0);
            hist_top.push_back('0);
        end else begin
            hist_left.push_back(left);
            hist_top.push_back(top);
        end
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Cycle-exact value of diagonal d after the latest edge
    // Exit cell is on the bottom row or on the right column
    function automatic operand_t expected_lane(int d, int lane);
        int       i;
        int       j;
        int       k;
        int       m;
        int       e;
        int       k_max;
        operand_t acc;
        if (d < N) begin
            i = N - 1;
            j = d;
        end else begin
            i = 2 * N - 2 - d;
            j = N - 1;
        end
        m     = hist_left.size() - 1;
        k_max = (i < j) ? i : j;
        acc   = '0;
        // Walk back up the diagonal, one edge earlier per step
        for (k = 0; k <= k_max; k++) begin
            e = m - i - j + k;
            // Edges before the start of the run count as zero
            if (e >= 0) begin
                acc = acc + hist_left[e][i-k][lane] * hist_top[e][j-k];
            end
        end
        return acc;
    endfunction

    // Final value of diagonal d for operands held constant
    function automatic operand_t settled_lane(stim_row_t row, int d, int lane);
        int       i;
        int       j;
        operand_t acc;
        acc = '0;
        for (i = 0; i < N; i++) begin
            for (j = 0; j < N; j++) begin
                if (j - i + N - 1 == d) begin
                    acc = acc + row.left[i][lane] * row.top[j];
                end
            end
        end
        return acc;
    endfunction

    // Number of cells on diagonal d
    function automatic int cells_on_diag(int d);
        int diff;
        diff = d - (N - 1);
        if (diff < 0) begin
            diff = -diff;
        end
        return N - diff;
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_lane(string what, int d, int lane, operand_t exp_val);
        operand_t got;
        got = result[d][lane];
        assert (got == exp_val) else begin
            $display("FAILED t=%0t %s check result[%0d][%0d] expected=%h got=%h",
                     $time, what, d, lane, exp_val, got);
            $display("TB FAILED");
            $fatal(1, "result mismatch on diagonal %0d lane %0d", d, lane);
        end
    endtask

    // Every cycle, half way between edges
    always @(negedge clk) begin : cycle_check
        int d;
        int l;
        if (hist_left.size() > 0) begin
            for (d = 0; d < NUM_DIAG; d++) begin
                for (l = 0; l < LANES; l++) begin
                    check_lane("cycle", d, l, expected_lane(d, l));
                end
            end
        end
    end

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic build_table();
        int r;
        int i;
        int l;
        for (r = 0; r < NUM_ROWS; r++) begin
            stim_tbl[r] = '0;
        end
        // Idle zeros right after reset
        stim_tbl[0].hold = 3;
        // Single product, only row 0 and column 0 active
        for (l = 0; l < LANES; l++) begin
            stim_tbl[1].left[0][l] = operand_t'(3 + 2 * l);
        end
        stim_tbl[1].top[0]      = operand_t'(7);
        stim_tbl[1].hold        = SETTLE_HOLD;
        stim_tbl[1].settle_chk  = 1'b1;
        // All ones everywhere
        for (i = 0; i < N; i++) begin
            for (l = 0; l < LANES; l++) begin
                stim_tbl[ONES_ROW].left[i][l] = operand_t'(1);
            end
            stim_tbl[ONES_ROW].top[i] = operand_t'(1);
        end
        stim_tbl[ONES_ROW].hold       = SETTLE_HOLD;
        stim_tbl[ONES_ROW].settle_chk = 1'b1;
        // Large distinct lanes, products wrap
        for (i = 0; i < N; i++) begin
            for (l = 0; l < LANES; l++) begin
                stim_tbl[3].left[i][l] = operand_t'(61453 + i * 4951 + l * 2865);
            end
            stim_tbl[3].top[i] = operand_t'(65521 - i * 1911);
        end
        stim_tbl[3].hold       = SETTLE_HOLD;
        stim_tbl[3].settle_chk = 1'b1;
        // Fresh random operands on every cycle
        stim_tbl[4].hold    = 48;
        stim_tbl[4].rand_en = 1'b1;
        // Drain back to zero
        stim_tbl[5].hold       = SETTLE_HOLD;
        stim_tbl[5].settle_chk = 1'b1;
        table_ready = 1'b1;
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin : main_seq
        int r;
        int c;
        int i;
        int l;
        int d;
        left        = '0;
        top         = '0;
        arst_n      = 1'b0;
        table_ready = 1'b0;
        void'($urandom(32'h5228cd5c));
        build_table();

        // Reset for two edges, released off the edge
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;

        for (r = 0; r < NUM_ROWS; r++) begin
            for (c = 0; c < stim_tbl[r].hold; c++) begin
                if (stim_tbl[r].rand_en) begin
                    for (i = 0; i < N; i++) begin
                        for (l = 0; l < LANES; l++) begin
                            left[i][l] = operand_t'($urandom);
                        end
                        top[i] = operand_t'($urandom);
                    end
                end else begin
                    left = stim_tbl[r].left;
                    top  = stim_tbl[r].top;
                end
                @(posedge clk);
                #2;
            end
            // Closed-form sums once the front has crossed the grid
            if (stim_tbl[r].settle_chk) begin
                for (d = 0; d < NUM_DIAG; d++) begin
                    for (l = 0; l < LANES; l++) begin
                        check_lane("settled", d, l, settled_lane(stim_tbl[r], d, l));
                        if (r == ONES_ROW) begin
                            check_lane("cell count", d, l, operand_t'(cells_on_diag(d)));
                        end
                    end
                end
            end
        end

        $display("TB PASSED");
        $finish;
    end

    ////////////////////
    // Watchdog
    ////////////////////

    // Table length plus 4N cycles of margin and the reset cycles
    initial begin : watchdog
        int total;
        int r;
        wait (table_ready);
        total = 0;
        for (r = 0; r < NUM_ROWS; r++) begin
            total = total + stim_tbl[r].hold;
        end
        #((total + 4 * N + 2) * CLK_PERIOD);
        $display("Simulation timed out before the stimulus table was finished");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* src.f */
+incdir+include
logic/systolic_pkg.sv
logic/operand_skew.sv
logic/mac_cell.sv
logic/mac_grid.sv
logic/systolic_top.sv
bench/systolic_tb.sv

/* Makefile */
# Verilator flow for the systolic MAC array
# Any variable can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= systolic_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TB PASSED

.PHONY: sim clean

# Build, run and grep the log for the pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed, see $(LOG)"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
